//--- files.f
+incdir+hdl
hdl/noc_params.sv
hdl/vc_params.sv
hdl/circular_buffer.sv
hdl/vc_demux.sv
hdl/vc_arbiter.sv
hdl/input_port.sv
tb/tb_input_port.sv

//--- Bender.yml
package:
  name: noc_input_port

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/noc_params.sv
      - hdl/vc_params.sv
      - hdl/circular_buffer.sv
      - hdl/vc_demux.sv
      - hdl/vc_arbiter.sv
      - hdl/input_port.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_input_port.sv

//--- tb/tb_input_port.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module tb_input_port
    import noc_params::*, vc_params::*;
();

    localparam int VC   = `NOC_VC_NUM;
    localparam int SIZE = `NOC_BUFFER_SIZE;
    localparam int PD   = `NOC_PIPELINE_DEPTH;

    logic     clk = 1'b0;
    logic     rst;
    flit_t    flit_i;
    logic     write_i;
    logic     stall_i;
    flit_t    flit_o;
    logic     valid_o;
    vc_mask_t on_off_o;

    // one stimulus entry per cycle
    // an on_off of -1 is not checked
    string step_name [$];
    flit_t step_flit [$];
    bit    step_write [$];
    bit    step_stall [$];
    int    step_onoff [$];

    // reference model state
    flit_t    m_mem [VC][SIZE];
    int       m_rd [VC];
    int       m_cnt [VC];
    vc_mask_t m_onoff;
    bit       m_locked;
    int       m_lvc;
    int       m_ptr;
    bit       m_valid;
    flit_t    exp_q [$];

    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;
    int cycle_limit = 100000;

    input_port dut (
        .clk      (clk),
        .rst      (rst),
        .flit_i   (flit_i),
        .write_i  (write_i),
        .stall_i  (stall_i),
        .flit_o   (flit_o),
        .valid_o  (valid_o),
        .on_off_o (on_off_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("Error %s %s expected 'h%0h actual 'h%0h", test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic add_step(input string name, input flit_label_t label, input int vc,
                            input int payload, input bit wr, input bit st, input int onoff);
        flit_t f;
        f.label   = label;
        f.vc_id   = vc_id_t'(vc);
        f.payload = payload_t'(payload);
        step_name.push_back(name);
        step_flit.push_back(f);
        step_write.push_back(wr);
        step_stall.push_back(st);
        step_onoff.push_back(onoff);
    endtask

    // **************************************************
    // stimulus table
    // **************************************************

    task automatic build_table();
        flit_label_t lab;
        logic [31:0] rng;
        int          v;
        int          len;
        bit          st;
        for (int k = 0; k < 4; k++)
        begin
            lab = (k == 0) ? HEAD : (k == 3) ? TAIL : BODY;
            add_step("single_order", lab, 1, 'h1100 + k, 1, 0, 'hF);
        end
        repeat (6) add_step("single_order", HEAD, 0, 0, 0, 0, 'hF);
        // channels 0 and 2 written flit by flit in turn
        for (int k = 0; k < 4; k++)
        begin
            lab = (k == 0) ? HEAD : (k == 3) ? TAIL : BODY;
            add_step("no_interleave", lab, 0, 'h2000 + k, 1, 0, 'hF);
            add_step("no_interleave", lab, 2, 'h2200 + k, 1, 0, 'hF);
        end
        repeat (12) add_step("no_interleave", HEAD, 0, 0, 0, 0, 'hF);
        for (int r = 0; r < 2; r++)
            for (int c = 0; c < VC; c++)
                add_step("round_robin", HEADTAIL, c, 'h3000 + 16 * r + c, 1, 1, 'hF);
        repeat (12) add_step("round_robin", HEAD, 0, 0, 0, 0, 'hF);
        // seven flits on channel 1 turn it off once six are held
        for (int k = 0; k < 7; k++)
        begin
            lab = (k == 0) ? HEAD : (k == 6) ? TAIL : BODY;
            add_step("on_off", lab, 1, 'h4000 + k, 1, 1, (k + 1 > 5) ? 'hD : 'hF);
        end
        // one read per cycle turns it back on once two remain
        for (int k = 0; k < 9; k++)
            add_step("on_off", HEAD, 0, 0, 0, 0, (6 - k >= 3) ? 'hD : 'hF);
        for (int k = 0; k < 10; k++)
        begin
            lab = (k == 0) ? HEAD : BODY;
            add_step("overflow", lab, 3, 'h5000 + k, 1, 1, (k + 1 > 5) ? 'h7 : 'hF);
        end
        repeat (12) add_step("overflow", HEAD, 0, 0, 0, 0, -1);
        // the tail was lost in the overflow so a new one closes the packet
        add_step("overflow", TAIL, 3, 'h50FF, 1, 0, -1);
        repeat (4) add_step("overflow", HEAD, 0, 0, 0, 0, -1);
        rng = 32'd72;
        for (int p = 0; p < 24; p++)
        begin
            rng = xorshift(rng);
            v   = rng % VC;
            rng = xorshift(rng);
            len = rng % 4 + 1;
            for (int k = 0; k < len; k++)
            begin
                if (len == 1)
                    lab = HEADTAIL;
                else
                    lab = (k == 0) ? HEAD : (k == len - 1) ? TAIL : BODY;
                rng = xorshift(rng);
                st  = (rng[7:5] == 3'd0);
                if (rng[20])
                    add_step("random", HEAD, 0, 0, 0, st, -1);
                add_step("random", lab, v, rng[15:0], 1, st, -1);
            end
        end
        repeat (30) add_step("random", HEAD, 0, 0, 0, 0, -1);
    endtask

    // **************************************************
    // reference model called once per clock edge
    // **************************************************

    task automatic model_step();
        int    sel;
        int    idx;
        int    old;
        bit    found;
        bit    rd;
        bit    wr;
        flit_t f;
        found = 0;
        sel   = m_ptr;
        f     = '0;
        if (m_locked)
        begin
            sel   = m_lvc;
            found = (m_cnt[sel] != 0);
        end
        else
        begin
            for (int i = 0; i < VC; i++)
            begin
                idx = (m_ptr + i) % VC;
                if (!found && m_cnt[idx] != 0)
                begin
                    found = 1;
                    sel   = idx;
                end
            end
        end
        m_valid = found && !stall_i;
        if (m_valid)
        begin
            f = m_mem[sel][m_rd[sel]];
            exp_q.push_back(f);
        end
        for (int c = 0; c < VC; c++)
        begin
            old = m_cnt[c];
            rd  = m_valid && (sel == c);
            // a full channel takes a write only alongside a read
            wr  = write_i && (int'(flit_i.vc_id) == c) && (old < SIZE || rd);
            if (wr)
                m_mem[c][(m_rd[c] + old) % SIZE] = flit_i;
            if (rd)
                m_rd[c] = (m_rd[c] + 1) % SIZE;
            m_cnt[c] = old + wr - rd;
            if (m_cnt[c] < old && m_cnt[c] < PD)
                m_onoff[c] = 1'b1;
            else if (m_cnt[c] > old && m_cnt[c] > SIZE - PD)
                m_onoff[c] = 1'b0;
        end
        if (m_valid)
        begin
            if (!m_locked)
            begin
                if (f.label == HEAD)
                begin
                    m_locked = 1;
                    m_lvc    = sel;
                end
                else if (f.label == HEADTAIL || f.label == TAIL)
                    m_ptr = (sel + 1) % VC;
            end
            else if (f.label == TAIL || f.label == HEADTAIL)
            begin
                m_locked = 0;
                m_ptr    = (m_lvc + 1) % VC;
            end
        end
    endtask

    task automatic check_outputs(input string name, input int exp_onoff);
        flit_t want;
        compare(name, "valid_o", m_valid, valid_o);
        if (valid_o === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("%s: a flit left the port while none was expected", name);
                errors++;
                test_errors++;
            end
            else
            begin
                want = exp_q.pop_front();
                compare(name, "flit_o", want, flit_o);
            end
        end
        compare(name, "on_off_o vs model", m_onoff, on_off_o);
        if (exp_onoff >= 0)
            compare(name, "on_off_o", exp_onoff, on_off_o);
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial
    begin
        int n;
        rst     = 1'b1;
        flit_i  = '0;
        write_i = 1'b0;
        stall_i = 1'b0;
        for (int c = 0; c < VC; c++)
        begin
            m_rd[c]  = 0;
            m_cnt[c] = 0;
        end
        m_onoff  = '1;
        m_locked = 0;
        m_lvc    = 0;
        m_ptr    = 0;
        m_valid  = 0;
        build_table();
        n = step_name.size();
        cycle_limit = 2 * n + 200;
        repeat (10) @(posedge clk);
        // outputs held by reset
        compare(step_name[0], "valid_o in reset", 0, valid_o);
        compare(step_name[0], "on_off_o in reset", (1 << VC) - 1, on_off_o);
        #1 rst = 1'b0;
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk);
            #1;
            model_step();
            if (i == 0)
                check_outputs(step_name[0], -1);
            else
                check_outputs(step_name[i - 1], step_onoff[i - 1]);
            if (i > 0 && (i == n || step_name[i] != step_name[i - 1]))
            begin
                $display("test %s finished with %0d errors", step_name[i - 1], test_errors);
                tests++;
                test_errors = 0;
            end
            if (i < n)
            begin
                flit_i  = step_flit[i];
                write_i = step_write[i];
                stall_i = step_stall[i];
            end
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d expected flits never left the port", exp_q.size());
            errors++;
        end
        for (int c = 0; c < VC; c++)
        begin
            if (m_cnt[c] != 0)
            begin
                $display("channel %0d still holds %0d flits at the end", c, m_cnt[c]);
                errors++;
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- hdl/input_port.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module input_port
    import noc_params::*, vc_params::*;
(
    input  logic     clk,
    input  logic     rst,
    input  flit_t    flit_i,
    input  logic     write_i,
    input  logic     stall_i,
    output flit_t    flit_o,
    output logic     valid_o,
    output vc_mask_t on_off_o
);

    vc_mask_t write_vec;
    vc_mask_t read_vec;
    vc_mask_t empty_vec;
    flit_t    head_flit [`NOC_VC_NUM];

    // **************************************************
    // steer incoming flits by vc_id
    // **************************************************

    vc_demux u_demux (
        .flit_i  (flit_i),
        .write_i (write_i),
        .write_o (write_vec)
    );

    // **************************************************
    // one buffer per virtual channel
    // **************************************************

    for (genvar g = 0; g < `NOC_VC_NUM; g++)
    begin : g_buf
        // full is not needed here, upstream follows on_off
        circular_buffer #(
            .BUFFER_SIZE    (`NOC_BUFFER_SIZE),
            .PIPELINE_DEPTH (`NOC_PIPELINE_DEPTH)
        ) u_buffer (
            .clk        (clk),
            .rst        (rst),
            .data_i     (flit_i),
            .read_i     (read_vec[g]),
            .write_i    (write_vec[g]),
            .data_o     (head_flit[g]),
            .is_full_o  (),
            .is_empty_o (empty_vec[g]),
            .on_off_o   (on_off_o[g])
        );
    end

    // **************************************************
    // drain toward the crossbar
    // **************************************************

    vc_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .head_flit_i (head_flit),
        .empty_i     (empty_vec),
        .stall_i     (stall_i),
        .read_o      (read_vec),
        .flit_o      (flit_o),
        .valid_o     (valid_o)
    );

endmodule

//--- hdl/vc_arbiter.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module vc_arbiter
    import noc_params::*, vc_params::*;
(
    input  logic     clk,
    input  logic     rst,
    input  flit_t    head_flit_i [`NOC_VC_NUM],
    input  vc_mask_t empty_i,
    input  logic     stall_i,
    output vc_mask_t read_o,
    output flit_t    flit_o,
    output logic     valid_o
);

    localparam int VC_NUM = `NOC_VC_NUM;

    arb_state_t state;
    arb_state_t state_next;
    vc_id_t     ptr;
    vc_id_t     ptr_next;
    vc_id_t     locked_vc;
    vc_id_t     locked_vc_next;
    vc_id_t     sel_vc;
    logic       sel_found;
    logic       issue;
    flit_t      sel_flit;

    // **************************************************
    // channel selection
    // **************************************************

    always_comb
    begin : select
        int idx;
        idx       = 0;
        sel_found = 1'b0;
        if (state == ARB_LOCKED)
        begin
            // held by one packet until its tail
            sel_vc    = locked_vc;
            sel_found = ~empty_i[locked_vc];
        end
        else
        begin
            sel_vc = ptr;
            // first non-empty channel at or after the pointer
            for (int i = 0; i < VC_NUM; i++)
            begin
                idx = int'(ptr) + i;
                if (idx >= VC_NUM)
                    idx = idx - VC_NUM;
                if (!sel_found && !empty_i[idx])
                begin
                    sel_found = 1'b1;
                    sel_vc    = vc_id_t'(idx);
                end
            end
        end
    end

    assign issue    = sel_found & ~stall_i;
    assign sel_flit = head_flit_i[sel_vc];

    always_comb
    begin
        read_o = '0;
        if (issue)
            read_o[sel_vc] = 1'b1;
    end

    // **************************************************
    // packet lock FSM
    // **************************************************

    always_comb
    begin
        state_next     = state;
        ptr_next       = ptr;
        locked_vc_next = locked_vc;
        if (issue)
        begin
            if (state == ARB_IDLE)
            begin
                if (sel_flit.label == HEAD)
                begin
                    state_next     = ARB_LOCKED;
                    locked_vc_next = sel_vc;
                end
                // single-flit packet, or a stray tail, frees the channel at once
                else if (sel_flit.label == HEADTAIL || sel_flit.label == TAIL)
                    ptr_next = next_vc(sel_vc);
            end
            else if (sel_flit.label == TAIL || sel_flit.label == HEADTAIL)
            begin
                state_next = ARB_IDLE;
                ptr_next   = next_vc(locked_vc);
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= ARB_IDLE;
            ptr       <= '0;
            locked_vc <= '0;
            valid_o   <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            ptr       <= ptr_next;
            locked_vc <= locked_vc_next;
            valid_o   <= issue;
        end
    end

    // output flit, meaningful only with valid_o
    always_ff @(posedge clk)
    begin
        if (issue)
            flit_o <= sel_flit;
    end

endmodule

//--- hdl/vc_demux.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module vc_demux
    import noc_params::*, vc_params::*;
(
    input  flit_t    flit_i,
    input  logic     write_i,
    output vc_mask_t write_o
);

    localparam int VC_NUM = `NOC_VC_NUM;

    // **************************************************
    // vc_id decode
    // **************************************************

    // one strobe per buffer, at most one bit set
    // indices at or past VC_NUM match no bit and are dropped
    always_comb
    begin
        write_o = '0;
        for (int v = 0; v < VC_NUM; v++)
        begin
            if (write_i && flit_i.vc_id == vc_id_t'(v))
                write_o[v] = 1'b1;
        end
    end

endmodule

//--- hdl/circular_buffer.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module circular_buffer
    import noc_params::*;
#(
    parameter int BUFFER_SIZE    = `NOC_BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = `NOC_PIPELINE_DEPTH
)(
    input  logic  clk,
    input  logic  rst,
    input  flit_t data_i,
    input  logic  read_i,
    input  logic  write_i,
    output flit_t data_o,
    output logic  is_full_o,
    output logic  is_empty_o,
    output logic  on_off_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    localparam ptr_t   LAST_SLOT  = ptr_t'(BUFFER_SIZE - 1);
    localparam count_t FULL_LEVEL = count_t'(BUFFER_SIZE);
    // on below this count while draining
    localparam count_t ON_LEVEL   = count_t'(PIPELINE_DEPTH);
    // off above this count while filling
    localparam count_t OFF_LEVEL  = count_t'(BUFFER_SIZE - PIPELINE_DEPTH);

    flit_t memory [BUFFER_SIZE];

    ptr_t   read_ptr;
    ptr_t   write_ptr;
    ptr_t   read_ptr_next;
    ptr_t   write_ptr_next;
    count_t count;
    count_t count_next;
    logic   full_next;
    logic   empty_next;
    logic   on_off_next;
    logic   read_ok;
    logic   write_ok;

    // **************************************************
    // accepted operations
    // **************************************************

    // a read needs data, a write needs room unless a read frees a slot
    assign read_ok  = read_i & ~is_empty_o;
    assign write_ok = write_i & (~is_full_o | read_ok);

    // head of the ring, straight from storage
    assign data_o = memory[read_ptr];

    always_ff @(posedge clk)
    begin
        if (write_ok)
            memory[write_ptr] <= data_i;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_ptr   <= '0;
            write_ptr  <= '0;
            count      <= '0;
            is_full_o  <= 1'b0;
            is_empty_o <= 1'b1;
            on_off_o   <= 1'b1;
        end
        else
        begin
            read_ptr   <= read_ptr_next;
            write_ptr  <= write_ptr_next;
            count      <= count_next;
            is_full_o  <= full_next;
            is_empty_o <= empty_next;
            on_off_o   <= on_off_next;
        end
    end

    // **************************************************
    // next state
    // **************************************************

    function automatic ptr_t inc_ptr(input ptr_t ptr);
        if (ptr == LAST_SLOT)
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    always_comb
    begin
        read_ptr_next  = read_ptr;
        write_ptr_next = write_ptr;
        count_next     = count;
        case ({read_ok, write_ok})
            2'b10:
            begin
                read_ptr_next = inc_ptr(read_ptr);
                count_next    = count - 1'b1;
            end
            2'b01:
            begin
                write_ptr_next = inc_ptr(write_ptr);
                count_next     = count + 1'b1;
            end
            // pass-through, count stays
            2'b11:
            begin
                read_ptr_next  = inc_ptr(read_ptr);
                write_ptr_next = inc_ptr(write_ptr);
            end
            default:
            begin
                count_next = count;
            end
        endcase
        full_next  = (count_next == FULL_LEVEL);
        empty_next = (count_next == '0);
    end

    // hysteresis, the flag only moves with the count direction
    always_comb
    begin
        if (count_next < count && count_next < ON_LEVEL)
            on_off_next = 1'b1;
        else if (count_next > count && count_next > OFF_LEVEL)
            on_off_next = 1'b0;
        else
            on_off_next = on_off_o;
    end

endmodule

//--- hdl/vc_params.sv
`include "noc_config.svh"

package vc_params;

    import noc_params::*;

    // one bit per virtual channel
    typedef logic [`NOC_VC_NUM-1:0] vc_mask_t;

    // arbiter is free, or held by one packet
    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

    // next channel index, wraps at the channel count
    function automatic vc_id_t next_vc(input vc_id_t vc);
        if (int'(vc) >= `NOC_VC_NUM - 1)
            return '0;
        else
            return vc + 1'b1;
    endfunction

endpackage

//--- hdl/noc_params.sv
`include "noc_config.svh"

package noc_params;

    // **************************************************
    // flit format
    // **************************************************

    // width of the virtual channel field, at least one bit
    localparam int VC_ID_W = (`NOC_VC_NUM > 1) ? $clog2(`NOC_VC_NUM) : 1;

    // position of a flit inside its packet
    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_label_t;

    typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

    // virtual channel the flit travels on
    typedef logic [VC_ID_W-1:0] vc_id_t;

    // label in the top bits, payload at the bottom
    typedef struct packed {
        flit_label_t label;
        vc_id_t      vc_id;
        payload_t    payload;
    } flit_t;

endpackage

//--- hdl/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// **************************************************
// input port configuration
// **************************************************

// virtual channels per input port
`define NOC_VC_NUM 4

// depth of each virtual channel buffer, in flits
`define NOC_BUFFER_SIZE 8

// on/off margin, covers the flits in flight on the link
`define NOC_PIPELINE_DEPTH 3

// flit payload width
`define NOC_PAYLOAD_W 16
`endif
